// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_periph
FILELIST = vlog.f
OBJDIR   = obj_dir
PASS_MSG = SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and pass only if the pass message appears"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== bench/periph_asserts.sv ====
/*
 * Port-level checker for swervolf_periph, bound into every instance.
 * Register state is shadowed from acknowledged writes seen at the ports.
 */
module periph_asserts #(
   parameter int GPIO_W = 32
) (
   input logic              i_clk,
   input logic              i_rst_n,
   input wb_pkg::wb_addr_t  i_wb_adr,
   input wb_pkg::wb_data_t  i_wb_dat,
   input logic              i_wb_we,
   input logic              i_wb_cyc,
   input logic              i_wb_stb,
   input wb_pkg::wb_data_t  o_wb_rdt,
   input logic              o_wb_ack,
   input logic [GPIO_W-1:0] i_gpio0_in,
   input logic [GPIO_W-1:0] o_gpio0_out,
   input logic [GPIO_W-1:0] o_gpio0_oe,
   input logic [GPIO_W-1:0] i_gpio1_in,
   input logic [GPIO_W-1:0] o_gpio1_out,
   input logic [GPIO_W-1:0] o_gpio1_oe,
   input logic              o_irq
);
   timeunit 1ns;
   timeprecision 1ps;
   import wb_pkg::*;
   import periph_map_pkg::*;

   int          fail_count = 0;
   slv_sel_t    sel;
   reg_idx_t    idx;
   logic        req;
   logic        wr_ack;
   logic        mask_wr;
   logic        tmr_ctrl_wr;
   logic        tmr_cnt_wr;
   logic        disarm;
   irq_vec_t    mask_q;
   irq_vec_t    mask_eff;
   logic [GPIO_W-1:0] en0_q;
   wb_data_t    wr_dat_q;
   wb_data_t    cmp_q;
   logic        cnt_zeroed;
   logic        armed;
   logic        hit;
   logic [32:0] wait_cnt;

   assign sel         = i_wb_adr[15:12];
   assign idx         = i_wb_adr[5:2];
   assign req         = i_wb_cyc && i_wb_stb;
   assign wr_ack      = o_wb_ack && req && i_wb_we;
   assign mask_wr     = wr_ack && sel == SLV_SYSCON && idx == SYS_MASK;
   assign tmr_ctrl_wr = wr_ack && sel == SLV_TIMER && idx == TMR_CTRL;
   assign tmr_cnt_wr  = wr_ack && sel == SLV_TIMER && idx == TMR_COUNT;
   assign disarm      = tmr_ctrl_wr || tmr_cnt_wr || mask_wr;
   // MASK changes on the edge that raises ack
   assign mask_eff    = mask_wr ? i_wb_dat[N_IRQ-1:0] : mask_q;

   //************************************************************
   // Shadow registers
   //************************************************************
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         mask_q     <= '0;
         en0_q      <= '0;
         wr_dat_q   <= '0;
         cmp_q      <= '0;
         cnt_zeroed <= 1'b0;
         armed      <= 1'b0;
         hit        <= 1'b0;
         wait_cnt   <= '0;
      end else begin
         mask_q <= mask_eff;
         if (wr_ack) begin
            wr_dat_q <= i_wb_dat;
         end
         if (wr_ack && sel == SLV_GPIO0 && idx == GPIO_IRQ_EN) begin
            en0_q <= i_wb_dat[GPIO_W-1:0];
         end
         if (wr_ack && sel == SLV_TIMER && idx == TMR_COMPARE) begin
            cmp_q <= i_wb_dat;
         end
         if (tmr_cnt_wr) begin
            cnt_zeroed <= (i_wb_dat == '0);
         end else if (tmr_ctrl_wr) begin
            cnt_zeroed <= 1'b0;
         end
         if (tmr_ctrl_wr && i_wb_dat[0] && mask_eff[IRQ_TIMER] && cnt_zeroed) begin
            armed    <= 1'b1;
            hit      <= 1'b0;
            wait_cnt <= '0;
         end else if (disarm) begin
            armed <= 1'b0;
            hit   <= 1'b0;
         end else if (armed) begin
            wait_cnt <= wait_cnt + 33'd1;
            if (o_irq) begin
               hit <= 1'b1;
            end
         end
      end
   end

   //************************************************************
   // Handshake
   //************************************************************
   a_ack_reset: assert property (@(posedge i_clk) !i_rst_n |=> !o_wb_ack)
      else begin fail_count++; $error("o_wb_ack high after reset"); end

   a_ack_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (req && !o_wb_ack) |=> o_wb_ack)
      else begin fail_count++; $error("no ack one cycle after request"); end

   a_ack_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_wb_ack |=> !o_wb_ack)
      else begin fail_count++; $error("o_wb_ack held longer than one cycle"); end

   a_unmapped: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (req && !o_wb_ack && sel > SLV_SYSCON) |=> (o_wb_ack && o_wb_rdt == '0))
      else begin
         fail_count++;
         $error("error o_wb_rdt %h expected 00000000 on unmapped access", o_wb_rdt);
      end

   //************************************************************
   // GPIO outputs and readback
   //************************************************************
   a_out0: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (wr_ack && sel == SLV_GPIO0 && idx == GPIO_OUT)
      |=> o_gpio0_out == wr_dat_q[GPIO_W-1:0])
      else begin
         fail_count++;
         $error("error o_gpio0_out %h expected %h", o_gpio0_out, wr_dat_q[GPIO_W-1:0]);
      end

   a_oe0: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (wr_ack && sel == SLV_GPIO0 && idx == GPIO_OE)
      |=> o_gpio0_oe == wr_dat_q[GPIO_W-1:0])
      else begin
         fail_count++;
         $error("error o_gpio0_oe %h expected %h", o_gpio0_oe, wr_dat_q[GPIO_W-1:0]);
      end

   a_out1: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (wr_ack && sel == SLV_GPIO1 && idx == GPIO_OUT)
      |=> o_gpio1_out == wr_dat_q[GPIO_W-1:0])
      else begin
         fail_count++;
         $error("error o_gpio1_out %h expected %h", o_gpio1_out, wr_dat_q[GPIO_W-1:0]);
      end

   a_oe1: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (wr_ack && sel == SLV_GPIO1 && idx == GPIO_OE)
      |=> o_gpio1_oe == wr_dat_q[GPIO_W-1:0])
      else begin
         fail_count++;
         $error("error o_gpio1_oe %h expected %h", o_gpio1_oe, wr_dat_q[GPIO_W-1:0]);
      end

   a_rd0: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_wb_ack && req && !i_wb_we && sel == SLV_GPIO0 && idx == GPIO_OUT)
      |-> o_wb_rdt == wb_data_t'(o_gpio0_out))
      else begin
         fail_count++;
         $error("error o_wb_rdt %h expected %h", o_wb_rdt, o_gpio0_out);
      end

   a_rd1: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_wb_ack && req && !i_wb_we && sel == SLV_GPIO1 && idx == GPIO_OUT)
      |-> o_wb_rdt == wb_data_t'(o_gpio1_out))
      else begin
         fail_count++;
         $error("error o_wb_rdt %h expected %h", o_wb_rdt, o_gpio1_out);
      end

   //************************************************************
   // Interrupts
   //************************************************************
   a_gpio_irq: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      ((|(i_gpio0_in & ~$past(i_gpio0_in) & en0_q)) && mask_eff[IRQ_GPIO0] && !o_irq)
      |=> !o_irq ##1 !o_irq ##1 o_irq)
      else begin fail_count++; $error("o_irq did not rise 3 cycles after a GPIO edge"); end

   a_gpio_clr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (wr_ack && sel == SLV_GPIO0 && idx == GPIO_IRQ_STAT &&
       (i_wb_dat[GPIO_W-1:0] & en0_q) == en0_q && mask_eff == irq_vec_t'(1))
      |=> !o_irq)
      else begin fail_count++; $error("o_irq still high after clearing IRQ_STAT"); end

   a_tmr_rise: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (armed && !hit && !o_irq) |-> wait_cnt <= {1'b0, cmp_q})
      else begin fail_count++; $error("timer interrupt late for compare %h", cmp_q); end

   a_tmr_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (hit && !disarm) |-> o_irq)
      else begin fail_count++; $error("timer interrupt dropped while still enabled"); end

   a_masked: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (mask_eff == '0) |-> !o_irq)
      else begin fail_count++; $error("o_irq high while MASK is zero"); end

endmodule

bind swervolf_periph periph_asserts #(.GPIO_W(GPIO_W)) u_periph_asserts (.*);

// ==== bench/tb_periph.sv ====
/*
 * Testbench for swervolf_periph with GPIO_W = 32.
 * Checking is done by the bound assertions; this drives the bus and pins.
 */
module tb_periph;
   timeunit 1ns;
   timeprecision 1ps;
   import wb_pkg::*;
   import periph_map_pkg::*;

   localparam int GPIO_W  = 32;
   localparam int TIMEOUT = 100;

   logic              i_clk;
   logic              i_rst_n;
   wb_addr_t          i_wb_adr;
   wb_data_t          i_wb_dat;
   logic              i_wb_we;
   logic              i_wb_cyc;
   logic              i_wb_stb;
   wb_data_t          o_wb_rdt;
   logic              o_wb_ack;
   logic [GPIO_W-1:0] i_gpio0_in;
   logic [GPIO_W-1:0] o_gpio0_out;
   logic [GPIO_W-1:0] o_gpio0_oe;
   logic [GPIO_W-1:0] i_gpio1_in;
   logic [GPIO_W-1:0] o_gpio1_out;
   logic [GPIO_W-1:0] o_gpio1_oe;
   logic              o_irq;

   logic [31:0] rng_state = 32'd31;
   int          timeouts  = 0;
   int          tests     = 0;

   swervolf_periph #(.GPIO_W(GPIO_W)) u_swervolf_periph (.*);

   always #4 i_clk = ~i_clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   function automatic wb_addr_t reg_addr(input slv_sel_t sel, input reg_idx_t idx);
      return {sel, 6'b0, idx, 2'b00};
   endfunction

   // Request on one edge, hold until ack, release on the ack edge
   task automatic bus_access(input wb_addr_t adr, input wb_data_t dat, input logic we,
                             output wb_data_t rdt);
      int n;
      n = 0;
      @(posedge i_clk);
      i_wb_adr <= adr;
      i_wb_dat <= dat;
      i_wb_we  <= we;
      i_wb_cyc <= 1'b1;
      i_wb_stb <= 1'b1;
      do begin
         @(posedge i_clk);
         n++;
      end while (!o_wb_ack && n < TIMEOUT);
      rdt = o_wb_rdt;
      if (!o_wb_ack) begin
         timeouts++;
         $display("bus access to address %h was never acknowledged", adr);
      end
      i_wb_cyc <= 1'b0;
      i_wb_stb <= 1'b0;
      i_wb_we  <= 1'b0;
   endtask

   task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
      wb_data_t unused;
      bus_access(adr, dat, 1'b1, unused);
   endtask

   task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
      bus_access(adr, '0, 1'b0, dat);
   endtask

   task automatic wait_irq(input string what);
      int n;
      n = 0;
      while (!o_irq && n < TIMEOUT) begin
         @(posedge i_clk);
         n++;
      end
      if (!o_irq) begin
         timeouts++;
         $display("interrupt from %s never arrived", what);
      end
   endtask

   task automatic test_done(input string name);
      tests++;
      $display("test %s finished, timeouts so far %0d", name, timeouts);
   endtask

   initial begin
      wb_data_t    rd;
      int          bit_k;
      logic [31:0] cmp;
      i_clk      = 1'b0;
      i_rst_n    = 1'b0;
      i_wb_adr   = '0;
      i_wb_dat   = '0;
      i_wb_we    = 1'b0;
      i_wb_cyc   = 1'b0;
      i_wb_stb   = 1'b0;
      i_gpio0_in = '0;
      i_gpio1_in = '0;
      repeat (2) @(posedge i_clk);
      i_rst_n <= 1'b1;
      repeat (2) @(posedge i_clk);
      test_done("reset");

      wb_read(16'h5000, rd);
      wb_write(16'hF004, next_rand());
      wb_read(16'hA010, rd);
      test_done("unmapped");

      for (int i = 0; i < 4; i++) begin
         wb_write(reg_addr(SLV_GPIO0, GPIO_OUT), next_rand());
         wb_write(reg_addr(SLV_GPIO0, GPIO_OE), next_rand());
         wb_write(reg_addr(SLV_GPIO1, GPIO_OUT), next_rand());
         wb_write(reg_addr(SLV_GPIO1, GPIO_OE), next_rand());
         wb_read(reg_addr(SLV_GPIO0, GPIO_OUT), rd);
         wb_read(reg_addr(SLV_GPIO1, GPIO_OUT), rd);
      end
      test_done("gpio_out");

      bit_k = int'(next_rand() % 32);
      wb_write(reg_addr(SLV_GPIO0, GPIO_IRQ_EN), 32'd1 << bit_k);
      wb_write(reg_addr(SLV_SYSCON, SYS_MASK), 32'd1 << IRQ_GPIO0);
      @(posedge i_clk);
      i_gpio0_in <= 32'd1 << bit_k;
      wait_irq("gpio0");
      wb_write(reg_addr(SLV_GPIO0, GPIO_IRQ_STAT), 32'd1 << bit_k);
      repeat (2) @(posedge i_clk);
      i_gpio0_in <= '0;
      test_done("gpio_irq");

      cmp = (next_rand() % 16) + 4;
      wb_write(reg_addr(SLV_TIMER, TMR_COMPARE), cmp);
      wb_write(reg_addr(SLV_TIMER, TMR_COUNT), '0);
      wb_write(reg_addr(SLV_SYSCON, SYS_MASK), 32'd1 << IRQ_TIMER);
      wb_write(reg_addr(SLV_TIMER, TMR_CTRL), 32'd1);
      wait_irq("timer");
      repeat (8) @(posedge i_clk);
      wb_write(reg_addr(SLV_TIMER, TMR_CTRL), 32'd0);
      test_done("timer");

      // Timer and GPIO1 sources active with everything masked
      wb_write(reg_addr(SLV_SYSCON, SYS_MASK), 32'd0);
      wb_write(reg_addr(SLV_TIMER, TMR_CTRL), 32'd1);
      wb_write(reg_addr(SLV_GPIO1, GPIO_IRQ_EN), '1);
      @(posedge i_clk);
      i_gpio1_in <= next_rand();
      repeat (10) @(posedge i_clk);
      wb_read(reg_addr(SLV_SYSCON, SYS_PENDING), rd);
      wb_write(reg_addr(SLV_TIMER, TMR_CTRL), 32'd0);
      test_done("masking");

      repeat (2) @(posedge i_clk);
      $display("tests %0d, timeouts %0d, assertion failures %0d", tests, timeouts,
               u_swervolf_periph.u_periph_asserts.fail_count);
      if (timeouts == 0 && u_swervolf_periph.u_periph_asserts.fail_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== design/cmp_timer.sv ====
/*
 * Free-running 32-bit counter, enabled by CTRL bit 0.
 * The interrupt stays up while enabled and COUNT >= COMPARE.
 */
module cmp_timer (
   input  logic i_clk,
   input  logic i_rst_n,
   wb_if.slave  bus,
   output logic o_irq
);
   import wb_pkg::*;
   import periph_map_pkg::*;

   wb_data_t count_q;
   wb_data_t compare_q;
   logic     en_q;
   reg_idx_t idx;
   logic     wr_en;

   assign idx   = bus.adr[5:2];
   assign wr_en = bus.cyc & bus.stb & ~bus.ack & bus.we;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         bus.ack   <= 1'b0;
         count_q   <= '0;
         compare_q <= '0;
         en_q      <= 1'b0;
      end else begin
         bus.ack <= bus.cyc & bus.stb & ~bus.ack;
         // Software write to COUNT overrides the increment
         if (wr_en && idx == TMR_COUNT) begin
            count_q <= bus.dat;
         end else if (en_q) begin
            count_q <= count_q + 1'b1;
         end
         if (wr_en && idx == TMR_COMPARE) begin
            compare_q <= bus.dat;
         end
         if (wr_en && idx == TMR_CTRL) begin
            en_q <= bus.dat[0];
         end
      end
   end

   always_comb begin
      case (idx)
         TMR_COUNT:   bus.rdt = count_q;
         TMR_COMPARE: bus.rdt = compare_q;
         TMR_CTRL:    bus.rdt = {{(DATA_W-1){1'b0}}, en_q};
         default:     bus.rdt = '0;
      endcase
   end

   assign o_irq = en_q && (count_q >= compare_q);

endmodule

// ==== design/gpio_bank.sv ====
/*
 * GPIO bank of GPIO_W pins (1 to 32), upper read bits are zero.
 * Inputs pass a two-flop synchroniser; rising edges latch into
 * IRQ_STAT, write 1 to clear. A new edge beats a clear.
 */
module gpio_bank #(
   parameter int GPIO_W = 32
) (
   input  logic              i_clk,
   input  logic              i_rst_n,
   wb_if.slave               bus,
   input  logic [GPIO_W-1:0] i_pin,
   output logic [GPIO_W-1:0] o_pin,
   output logic [GPIO_W-1:0] o_pin_oe,
   output logic              o_irq
);
   import wb_pkg::*;
   import periph_map_pkg::*;

   typedef logic [GPIO_W-1:0] pin_t;

   pin_t     in_meta;
   pin_t     in_sync;
   pin_t     in_dly;
   pin_t     rise;
   pin_t     out_q;
   pin_t     oe_q;
   pin_t     irq_en_q;
   pin_t     irq_stat_q;
   pin_t     stat_clr;
   pin_t     wr_data;
   reg_idx_t idx;
   logic     wr_en;

   assign idx     = bus.adr[5:2];
   assign wr_data = bus.dat[GPIO_W-1:0];
   assign wr_en   = bus.cyc & bus.stb & ~bus.ack & bus.we;

   //**********************************************************
   // Input synchroniser and edge detect
   //**********************************************************
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         in_meta <= '0;
         in_sync <= '0;
         in_dly  <= '0;
      end else begin
         in_meta <= i_pin;
         in_sync <= in_meta;
         in_dly  <= in_sync;
      end
   end

   assign rise = in_sync & ~in_dly;

   //**********************************************************
   // Bus side
   //**********************************************************
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         bus.ack <= 1'b0;
      end else begin
         bus.ack <= bus.cyc & bus.stb & ~bus.ack;
      end
   end

   assign stat_clr = (wr_en && idx == GPIO_IRQ_STAT) ? wr_data : '0;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         out_q      <= '0;
         oe_q       <= '0;
         irq_en_q   <= '0;
         irq_stat_q <= '0;
      end else begin
         if (wr_en && idx == GPIO_OUT) begin
            out_q <= wr_data;
         end
         if (wr_en && idx == GPIO_OE) begin
            oe_q <= wr_data;
         end
         if (wr_en && idx == GPIO_IRQ_EN) begin
            irq_en_q <= wr_data;
         end
         irq_stat_q <= (irq_stat_q & ~stat_clr) | rise;
      end
   end

   always_comb begin
      case (idx)
         GPIO_IN:       bus.rdt = wb_data_t'(in_sync);
         GPIO_OUT:      bus.rdt = wb_data_t'(out_q);
         GPIO_OE:       bus.rdt = wb_data_t'(oe_q);
         GPIO_IRQ_EN:   bus.rdt = wb_data_t'(irq_en_q);
         GPIO_IRQ_STAT: bus.rdt = wb_data_t'(irq_stat_q);
         default:       bus.rdt = '0;
      endcase
   end

   assign o_pin    = out_q;
   assign o_pin_oe = oe_q;
   assign o_irq    = |(irq_stat_q & irq_en_q);

endmodule

// ==== design/periph_map_pkg.sv ====
/*
 * Peripheral address map. Address bits 15:12 select the slave and
 * bits 5:2 select the register, so each slave has 16 word registers.
 */
package periph_map_pkg;

   localparam int SLAVE_SEL_W = 4;

   typedef logic [SLAVE_SEL_W-1:0] slv_sel_t;

   // Slave select values, the rest are unmapped
   localparam slv_sel_t SLV_GPIO0  = 4'd0;
   localparam slv_sel_t SLV_GPIO1  = 4'd1;
   localparam slv_sel_t SLV_TIMER  = 4'd2;
   localparam slv_sel_t SLV_SYSCON = 4'd3;

   typedef logic [3:0] reg_idx_t;

   localparam reg_idx_t GPIO_IN       = 4'd0;
   localparam reg_idx_t GPIO_OUT      = 4'd1;
   localparam reg_idx_t GPIO_OE       = 4'd2;
   localparam reg_idx_t GPIO_IRQ_EN   = 4'd3;
   localparam reg_idx_t GPIO_IRQ_STAT = 4'd4;

   localparam reg_idx_t TMR_COUNT   = 4'd0;
   localparam reg_idx_t TMR_COMPARE = 4'd1;
   localparam reg_idx_t TMR_CTRL    = 4'd2;

   localparam reg_idx_t SYS_PENDING = 4'd0;
   localparam reg_idx_t SYS_MASK    = 4'd1;

   // Bit positions in PENDING and MASK
   localparam int IRQ_GPIO0 = 0;
   localparam int IRQ_GPIO1 = 1;
   localparam int IRQ_TIMER = 2;
   localparam int N_IRQ     = 3;

   typedef logic [N_IRQ-1:0] irq_vec_t;

endpackage

// ==== design/swervolf_periph.sv ====
/*
 * Wishbone peripheral subsystem: two GPIO banks, compare timer, syscon.
 * GPIO pins come out as separate in, out and oe vectors.
 */
module swervolf_periph #(
   parameter int GPIO_W = 32
) (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  wb_pkg::wb_addr_t  i_wb_adr,
   input  wb_pkg::wb_data_t  i_wb_dat,
   input  logic              i_wb_we,
   input  logic              i_wb_cyc,
   input  logic              i_wb_stb,
   output wb_pkg::wb_data_t  o_wb_rdt,
   output logic              o_wb_ack,
   input  logic [GPIO_W-1:0] i_gpio0_in,
   output logic [GPIO_W-1:0] o_gpio0_out,
   output logic [GPIO_W-1:0] o_gpio0_oe,
   input  logic [GPIO_W-1:0] i_gpio1_in,
   output logic [GPIO_W-1:0] o_gpio1_out,
   output logic [GPIO_W-1:0] o_gpio1_oe,
   output logic              o_irq
);
   import periph_map_pkg::*;

   irq_vec_t irq_lines;

   wb_if bus_host ();
   wb_if bus_gpio0 ();
   wb_if bus_gpio1 ();
   wb_if bus_timer ();
   wb_if bus_sys ();

   assign bus_host.adr = i_wb_adr;
   assign bus_host.dat = i_wb_dat;
   assign bus_host.we  = i_wb_we;
   assign bus_host.cyc = i_wb_cyc;
   assign bus_host.stb = i_wb_stb;
   assign o_wb_rdt     = bus_host.rdt;
   assign o_wb_ack     = bus_host.ack;

   wb_decoder u_wb_decoder (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .s_host  (bus_host.slave),
      .m_gpio0 (bus_gpio0.master),
      .m_gpio1 (bus_gpio1.master),
      .m_timer (bus_timer.master),
      .m_sys   (bus_sys.master)
   );

   //**********************************************************
   // GPIO banks
   //**********************************************************
   gpio_bank #(.GPIO_W(GPIO_W)) u_gpio0 (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .bus      (bus_gpio0.slave),
      .i_pin    (i_gpio0_in),
      .o_pin    (o_gpio0_out),
      .o_pin_oe (o_gpio0_oe),
      .o_irq    (irq_lines[IRQ_GPIO0])
   );

   gpio_bank #(.GPIO_W(GPIO_W)) u_gpio1 (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .bus      (bus_gpio1.slave),
      .i_pin    (i_gpio1_in),
      .o_pin    (o_gpio1_out),
      .o_pin_oe (o_gpio1_oe),
      .o_irq    (irq_lines[IRQ_GPIO1])
   );

   cmp_timer u_cmp_timer (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .bus     (bus_timer.slave),
      .o_irq   (irq_lines[IRQ_TIMER])
   );

   syscon_irq u_syscon_irq (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .bus     (bus_sys.slave),
      .i_irq   (irq_lines),
      .o_irq   (o_irq)
   );

endmodule

// ==== design/syscon_irq.sv ====
/*
 * Interrupt collector. PENDING shows the raw source lines,
 * MASK gates them onto the single interrupt output.
 */
module syscon_irq (
   input  logic                     i_clk,
   input  logic                     i_rst_n,
   wb_if.slave                      bus,
   input  periph_map_pkg::irq_vec_t i_irq,
   output logic                     o_irq
);
   import wb_pkg::*;
   import periph_map_pkg::*;

   irq_vec_t mask_q;
   reg_idx_t idx;

   assign idx = bus.adr[5:2];

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         bus.ack <= 1'b0;
         mask_q  <= '0;
      end else begin
         bus.ack <= bus.cyc & bus.stb & ~bus.ack;
         if (bus.cyc && bus.stb && !bus.ack && bus.we && idx == SYS_MASK) begin
            mask_q <= bus.dat[N_IRQ-1:0];
         end
      end
   end

   always_comb begin
      case (idx)
         SYS_PENDING: bus.rdt = wb_data_t'(i_irq);
         SYS_MASK:    bus.rdt = wb_data_t'(mask_q);
         default:     bus.rdt = '0;
      endcase
   end

   assign o_irq = |(i_irq & mask_q);

endmodule

// ==== design/wb_decoder.sv ====
/*
 * One master, four slaves. Address bits 15:12 pick the slave.
 * Unmapped selects get a one-cycle ack with zero read data.
 */
module wb_decoder (
   input  logic i_clk,
   input  logic i_rst_n,
   wb_if.slave  s_host,
   wb_if.master m_gpio0,
   wb_if.master m_gpio1,
   wb_if.master m_timer,
   wb_if.master m_sys
);
   import wb_pkg::*;
   import periph_map_pkg::*;

   slv_sel_t sel;
   logic     unmapped;
   logic     unmap_ack;

   assign sel      = s_host.adr[ADDR_W-1 -: SLAVE_SEL_W];
   assign unmapped = (sel != SLV_GPIO0) && (sel != SLV_GPIO1) &&
                     (sel != SLV_TIMER) && (sel != SLV_SYSCON);

   // Shared request lines
   assign m_gpio0.adr = s_host.adr;
   assign m_gpio0.dat = s_host.dat;
   assign m_gpio0.we  = s_host.we;
   assign m_gpio0.cyc = s_host.cyc;
   assign m_gpio1.adr = s_host.adr;
   assign m_gpio1.dat = s_host.dat;
   assign m_gpio1.we  = s_host.we;
   assign m_gpio1.cyc = s_host.cyc;
   assign m_timer.adr = s_host.adr;
   assign m_timer.dat = s_host.dat;
   assign m_timer.we  = s_host.we;
   assign m_timer.cyc = s_host.cyc;
   assign m_sys.adr   = s_host.adr;
   assign m_sys.dat   = s_host.dat;
   assign m_sys.we    = s_host.we;
   assign m_sys.cyc   = s_host.cyc;

   // Strobe only reaches the addressed slave
   assign m_gpio0.stb = s_host.stb && (sel == SLV_GPIO0);
   assign m_gpio1.stb = s_host.stb && (sel == SLV_GPIO1);
   assign m_timer.stb = s_host.stb && (sel == SLV_TIMER);
   assign m_sys.stb   = s_host.stb && (sel == SLV_SYSCON);

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         unmap_ack <= 1'b0;
      end else begin
         unmap_ack <= s_host.cyc & s_host.stb & unmapped & ~unmap_ack;
      end
   end

   // Address is held until ack, so the return mux follows it
   always_comb begin
      case (sel)
         SLV_GPIO0: begin
            s_host.rdt = m_gpio0.rdt;
            s_host.ack = m_gpio0.ack;
         end
         SLV_GPIO1: begin
            s_host.rdt = m_gpio1.rdt;
            s_host.ack = m_gpio1.ack;
         end
         SLV_TIMER: begin
            s_host.rdt = m_timer.rdt;
            s_host.ack = m_timer.ack;
         end
         SLV_SYSCON: begin
            s_host.rdt = m_sys.rdt;
            s_host.ack = m_sys.ack;
         end
         default: begin
            s_host.rdt = '0;
            s_host.ack = unmap_ack;
         end
      endcase
   end

endmodule

// ==== design/wb_if.sv ====
/*
 * Wishbone classic bundle, no err, rty or sel.
 * The slave holds ack high for one cycle per access.
 */
interface wb_if;
   import wb_pkg::*;

   wb_addr_t adr;
   wb_data_t dat;
   logic     we;
   logic     cyc;
   logic     stb;
   wb_data_t rdt;
   logic     ack;

   modport master (
      output adr, dat, we, cyc, stb,
      input  rdt, ack
   );

   modport slave (
      input  adr, dat, we, cyc, stb,
      output rdt, ack
   );

endinterface

// ==== design/wb_pkg.sv ====
/*
 * Bus-level types for the peripheral Wishbone bus.
 * Word accesses only; there are no byte selects.
 */
package wb_pkg;

   // Byte address, bits 1:0 are ignored by every slave
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;

   typedef logic [ADDR_W-1:0] wb_addr_t;
   typedef logic [DATA_W-1:0] wb_data_t;

endpackage

// ==== vlog.f ====
design/wb_pkg.sv
design/periph_map_pkg.sv
design/wb_if.sv
design/wb_decoder.sv
design/gpio_bank.sv
design/cmp_timer.sv
design/syscon_irq.sv
design/swervolf_periph.sv
bench/periph_asserts.sv
bench/tb_periph.sv
